//--- flist.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/instr_buffer.sv
hw/fetch_out_stage.sv
hw/if_top.sv
sim/tb_clk_gen.sv
sim/imem_model.sv
sim/if_top_chk.sv
sim/tb_if_top.sv

//--- Makefile
SIM       := verilator
TOP       := tb_if_top
FLIST     := flist.f
SIM_FLAGS := --binary --timing --assert -Wno-fatal
RUN_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log
SRCS      := $(filter-out +incdir+%,$(shell cat $(FLIST)))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_if_top.sv
// only BUF_DEPTH 2 is run and the word at A is A xor PATTERN with faults from FAULT_BASE up
`timescale 1ns/1ps

module tb_if_top;
  import fetch_pkg::*;

  localparam int unsigned SEED       = 72;
  localparam int unsigned BUF_DEPTH  = 2;
  localparam int          TIMEOUT    = 2000;
  localparam addr_t       FAULT_BASE = 32'h0000_8000;
  localparam instr_t      PATTERN    = 32'ha5c3_0f69;

  // names match the DUT ports
  logic   clk, rst_n, req_i, branch_i, abort_pf_i, ready_i;
  logic   valid_o, instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_pmp_i;
  logic   fetch_failed_o, busy_o;
  addr_t  addr_i, pc_o, instr_addr_o;
  instr_t rdata_o, instr_rdata_i;

  // reference pc and counters
  // the monitor alone updates exp_pc and acc_cnt once running
  addr_t  exp_pc;
  int     acc_cnt;
  int     err_cnt;
  int     test_cnt;
  int     test_err;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(3)) u_tb_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  if_top #(.BUF_DEPTH(BUF_DEPTH)) u_if_top (.*);

  imem_model #(.FAULT_BASE(FAULT_BASE), .PATTERN(PATTERN)) u_imem_model (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req_o), .addr_i (instr_addr_o),
    .gnt_o (instr_gnt_i), .err_o (instr_err_pmp_i), .rvalid_o (instr_rvalid_i),
    .rdata_o (instr_rdata_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference and compare
  ////////////////////////////////////////////////////////////////////////////

  function automatic instr_t ref_word(input addr_t a);
    return a ^ PATTERN;
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // a branch restarts the expected stream
  // every accepted word is compared against the reference
  always @(posedge clk) begin
    if (rst_n && branch_i) begin
      exp_pc = addr_i;
    end else if (rst_n && valid_o && ready_i) begin
      check_addr("pc_o", pc_o, exp_pc);
      check_instr("rdata_o", rdata_o, ref_word(exp_pc));
      exp_pc  = exp_pc + WORD_BYTES;
      acc_cnt = acc_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic wait_accepts(input int target, input logic rand_ready, input string what);
    int t;
    t = 0;
    while (acc_cnt < target && t < TIMEOUT) begin
      if (rand_ready) begin
        ready_i = 1'($urandom % 2);
      end
      step();
      t++;
    end
    if (acc_cnt < target) begin
      stop_on_timeout(what);
    end
  endtask

  // want_fault selects a wait for fetch_failed_o over a wait for busy_o low
  task automatic wait_status(input logic want_fault, input string what);
    int t;
    t = 0;
    while ((want_fault ? !fetch_failed_o : busy_o) && t < TIMEOUT) begin
      step();
      t++;
    end
    if (want_fault ? !fetch_failed_o : busy_o) begin
      stop_on_timeout(what);
    end
  endtask

  // consumer never accepts in a branch cycle
  task automatic do_branch(input addr_t target);
    logic keep;
    keep       = ready_i;
    ready_i    = 1'b0;
    branch_i   = 1'b1;
    addr_i     = target;
    step();
    branch_i   = 1'b0;
    ready_i    = keep;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int mark;
    int gap;
    int total;
    void'($urandom(SEED));
    {req_i, branch_i, abort_pf_i, ready_i} = 4'b0000;
    addr_i   = '0;
    exp_pc   = '0;
    acc_cnt  = 0;
    err_cnt  = 0;
    test_cnt = 0;
    test_err = 0;
    repeat (5) step();
    // every status output is quiet after reset
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("instr_req_o", instr_req_o, 1'b0);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("fetch_failed_o", fetch_failed_o, 1'b0);

    // req and the first branch come together so nothing is fetched before the target
    req_i   = 1'b1;
    ready_i = 1'b1;
    do_branch(32'h0000_0100);
    wait_accepts(acc_cnt + 32, 1'b0, "sequential stream of 32 words");
    end_test("sequential");

    wait_accepts(acc_cnt + 48, 1'b1, "48 words under back-pressure");
    end_test("back-pressure");

    // branches land in any controller state and stale words must not show
    for (int i = 0; i < 12; i++) begin
      gap = $urandom % 6;
      repeat (gap) begin
        ready_i = 1'($urandom % 2);
        step();
      end
      do_branch(32'h0000_1000 + ((32'($urandom) % 256) << 2));
    end
    wait_accepts(acc_cnt + 8, 1'b1, "delivery after redirects");
    end_test("redirect");

    ready_i    = 1'b1;
    abort_pf_i = 1'b1;
    mark       = acc_cnt;
    repeat (30) step();
    if (acc_cnt - mark > BUF_DEPTH + 1) begin
      $display("abort: %0d words accepted while prefetch was held", acc_cnt - mark);
      err_cnt++;
    end
    check_flag("busy_o", busy_o, 1'b0);
    abort_pf_i = 1'b0;
    wait_accepts(acc_cnt + 8, 1'b0, "restart after abort");
    end_test("abort");

    // four good words and then the grant at FAULT_BASE faults
    do_branch(FAULT_BASE - 32'd16);
    wait_status(1'b1, "fetch_failed_o at the fault region");
    check_addr("next expected pc", exp_pc, FAULT_BASE);
    check_flag("valid_o", valid_o, 1'b0);
    repeat (5) step();
    check_flag("fetch_failed_o", fetch_failed_o, 1'b1);
    do_branch(32'h0000_2000);
    check_flag("fetch_failed_o", fetch_failed_o, 1'b0);
    wait_accepts(acc_cnt + 8, 1'b0, "delivery after fault recovery");
    end_test("fault");

    req_i = 1'b0;
    wait_status(1'b0, "busy_o low with req_i low");
    repeat (20) begin
      step();
      check_flag("busy_o", busy_o, 1'b0);
    end
    end_test("idle");

    total = err_cnt + int'(u_if_top.u_if_top_chk.fail_cnt);
    $display("%0d tests, %0d words checked, %0d check errors, %0d assertion errors",
             test_cnt, acc_cnt, err_cnt, u_if_top.u_if_top_chk.fail_cnt);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/if_top_chk.sv
// protocol checks only, no data values; sampled on the rising clock edge
`timescale 1ns/1ps

module if_top_chk (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    branch_i,
  input logic                    instr_req_o,
  input logic                    instr_gnt_i,
  input fetch_pkg::addr_t        instr_addr_o,
  input logic                    instr_rvalid_i,
  input logic                    valid_o,
  input logic                    fetch_failed_o,
  input fetch_pkg::fetch_state_e state_i,
  input logic                    out_i
);
  import fetch_pkg::*;

  // number of failed properties
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////////////////////

  // a waiting request keeps its address unless a branch replaces it
  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> branch_i || (instr_req_o && $stable(instr_addr_o)))
    else begin
      $error("instr_addr_o changed while the request waited for its grant");
      fail_cnt++;
    end

  a_rvalid_out : assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> out_i)
    else begin
      $error("instr_rvalid_i without an outstanding request");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // consumer side
  ////////////////////////////////////////////////////////////////////////////

  a_reset_valid : assert property (@(posedge clk) !rst_n |-> !valid_o)
    else begin
      $error("valid_o high during reset");
      fail_cnt++;
    end

  // fault only shown from WAIT_JUMP, never with a live request
  a_fail_req : assert property (@(posedge clk) disable iff (!rst_n)
    fetch_failed_o |-> !instr_req_o && (state_i == WAIT_JUMP))
    else begin
      $error("fetch_failed_o with instr_req_o or outside WAIT_JUMP");
      fail_cnt++;
    end

endmodule

bind if_top if_top_chk u_if_top_chk (
  .*,
  .state_i (u_fetch_ctrl.state_q),
  .out_i   (u_fetch_ctrl.out_q)
);

//--- sim/imem_model.sv
// behavioral memory; serves one request at a time, word at A is A xor PATTERN
`timescale 1ns/1ps

module imem_model #(
  parameter fetch_pkg::addr_t  FAULT_BASE = 32'h0000_8000,
  parameter fetch_pkg::instr_t PATTERN    = 32'ha5c3_0f69
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  fetch_pkg::addr_t  addr_i,
  output logic              gnt_o,
  output logic              err_o,
  output logic              rvalid_o,
  output fetch_pkg::instr_t rdata_o
);
  import fetch_pkg::*;

  // grant allowed this cycle, drawn once per clock
  logic       gnt_en;
  logic       pend;
  addr_t      pend_addr;
  logic [1:0] delay;

  assign gnt_o    = req_i & gnt_en;
  // protection error flagged with the grant
  assign err_o    = gnt_o & (addr_i >= FAULT_BASE);
  assign rvalid_o = pend & (delay == 2'd0);
  assign rdata_o  = pend_addr ^ PATTERN;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_en    <= 1'b0;
      pend      <= 1'b0;
      pend_addr <= '0;
      delay     <= '0;
    end else begin
      // about three grants in four cycles
      gnt_en <= (($urandom % 4) != 0);
      if (gnt_o) begin
        // response 1 to 3 cycles after the grant
        pend      <= 1'b1;
        pend_addr <= addr_i;
        delay     <= 2'($urandom % 3);
      end else if (rvalid_o) begin
        pend <= 1'b0;
      end else if (pend) begin
        delay <= delay - 2'd1;
      end
    end
  end

endmodule

//--- sim/tb_clk_gen.sv
// free-running clock; reset is released 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

  // reset low for RST_CYCLES rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- hw/if_top.sv
// fetch front end; BUF_DEPTH >= 2, one outstanding memory request
`timescale 1ns/1ps

module if_top #(
  parameter int unsigned BUF_DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  logic              branch_i,
  input  logic              abort_pf_i,
  input  logic              ready_i,
  input  fetch_pkg::addr_t  addr_i,
  output logic              valid_o,
  output fetch_pkg::instr_t rdata_o,
  output fetch_pkg::addr_t  pc_o,
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic              instr_err_pmp_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  output logic              fetch_failed_o,
  output logic              busy_o
);
  import fetch_pkg::*;

  // controller to buffer
  logic   drop;
  logic   flush;
  // buffer back to controller
  logic   room;
  // buffer to output stage
  logic   buf_valid;
  instr_t buf_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: memory requests
  ////////////////////////////////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .abort_pf_i      (abort_pf_i),
    .addr_i          (addr_i),
    .room_i          (room),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .drop_o          (drop),
    .flush_o         (flush),
    .fetch_failed_o  (fetch_failed_o),
    .busy_o          (busy_o),
    .buf_valid_i     (buf_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stage 2 and 3: buffering and pc tagging
  ////////////////////////////////////////////////////////////////////////////

  instr_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_instr_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_i  (flush),
    .drop_i   (drop),
    .rvalid_i (instr_rvalid_i),
    .rdata_i  (instr_rdata_i),
    .ready_i  (ready_i),
    .valid_o  (buf_valid),
    .rdata_o  (buf_rdata),
    .room_o   (room)
  );

  fetch_out_stage u_fetch_out_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .branch_i (branch_i),
    .addr_i   (addr_i),
    .valid_i  (buf_valid),
    .rdata_i  (buf_rdata),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .rdata_o  (rdata_o),
    .pc_o     (pc_o)
  );

endmodule

//--- hw/fetch_out_stage.sv
// pc tracks accepted words only; consumer must not accept in a branch cycle
`timescale 1ns/1ps

module fetch_out_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              branch_i,
  input  fetch_pkg::addr_t  addr_i,
  input  logic              valid_i,
  input  fetch_pkg::instr_t rdata_i,
  input  logic              ready_i,
  output logic              valid_o,
  output fetch_pkg::instr_t rdata_o,
  output fetch_pkg::addr_t  pc_o
);
  import fetch_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // head address
  ////////////////////////////////////////////////////////////////////////////

  // address of the word now at the head of the stream
  addr_t pc_q;
  addr_t pc_d;
  logic  accept;

  assign accept = valid_i & ready_i;

  always_comb begin
    pc_d = pc_q;
    // redirect restarts the stream at the target
    if (branch_i) begin
      pc_d = addr_i;
    end else if (accept) begin
      pc_d = pc_q + WORD_BYTES;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // consumer side
  ////////////////////////////////////////////////////////////////////////////

  // data and valid pass straight through, the pc is attached here
  assign valid_o = valid_i;
  assign rdata_o = rdata_i;
  // pc_q stays put under stall, so pc_o is stable with rdata_o
  assign pc_o    = pc_q;

endmodule

//--- hw/instr_buffer.sv
// BUF_DEPTH must be at least 2; no overflow guard, writer must respect room_o
`timescale 1ns/1ps

module instr_buffer #(
  parameter int unsigned BUF_DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  logic              drop_i,
  input  logic              rvalid_i,
  input  fetch_pkg::instr_t rdata_i,
  input  logic              ready_i,
  output logic              valid_o,
  output fetch_pkg::instr_t rdata_o,
  output logic              room_o
);
  import fetch_pkg::*;

  localparam int unsigned PTR_W  = $clog2(BUF_DEPTH);
  localparam int unsigned CNT_W  = $clog2(BUF_DEPTH + 1);
  // one slot is kept free for the word still in flight
  localparam int unsigned ALM_TH = BUF_DEPTH - 1;

  instr_t             mem [BUF_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   usage;
  logic               fifo_valid;
  logic               push;
  logic               pop;

  assign fifo_valid = (usage != '0);
  assign room_o     = (usage < CNT_W'(ALM_TH));

  // store only if bypass is impossible, i.e. older data waits or consumer stalls
  assign push = rvalid_i & ~drop_i & (fifo_valid | ~ready_i);
  assign pop  = fifo_valid & ready_i;

  // oldest stored word first, else the live response
  assign valid_o = fifo_valid | (rvalid_i & ~drop_i);
  assign rdata_o = fifo_valid ? mem[rd_ptr] : rdata_i;

  always_ff @(posedge clk) begin
    if (push && !flush_i) begin
      mem[wr_ptr] <= rdata_i;
    end
  end

  // flush wins over push and pop in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      usage  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      usage  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        usage <= usage + 1'b1;
      end else if (pop && !push) begin
        usage <= usage - 1'b1;
      end
    end
  end

endmodule

//--- hw/fetch_ctrl.sv
// one request outstanding at most; memory must return exactly one rvalid per grant
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  logic             branch_i,
  input  logic             abort_pf_i,
  input  fetch_pkg::addr_t addr_i,
  input  logic             room_i,
  output logic             instr_req_o,
  output fetch_pkg::addr_t instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  logic             instr_err_pmp_i,
  output logic             drop_o,
  output logic             flush_o,
  output logic             fetch_failed_o,
  output logic             busy_o,
  input  logic             buf_valid_i
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // last issued address, or target minus one word when a branch could not issue
  addr_t addr_q;
  addr_t addr_d;
  addr_t next_addr;

  logic  addr_load;
  logic  rewind;
  logic  issue;
  logic  fetch_en;
  // a granted request still waits for its response
  logic  out_q;

  ////////////////////////////////////////////////////////////////////////////
  // status and strobes to the buffer
  ////////////////////////////////////////////////////////////////////////////

  assign busy_o    = (state_q != IDLE) || instr_req_o;
  assign flush_o   = branch_i;
  assign fetch_en  = req_i & ~abort_pf_i;
  assign next_addr = {addr_q[31:2], 2'b00} + WORD_BYTES;

  // fault is shown only once the words fetched before it have drained
  assign fetch_failed_o = (state_q == WAIT_JUMP) & ~branch_i & ~buf_valid_i;

  ////////////////////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = next_addr;
    issue        = 1'b0;
    addr_load    = 1'b0;
    rewind       = 1'b0;
    drop_o       = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (branch_i) begin
          instr_addr_o = addr_i;
        end
        // a branch flushes the buffer, so room does not matter then
        if (fetch_en && (room_i || branch_i)) begin
          issue = 1'b1;
        end else if (branch_i) begin
          addr_load = 1'b1;
          rewind    = 1'b1;
        end
      end

      WAIT_GNT: begin
        // keep the request up, a branch may still swap the address
        instr_req_o  = 1'b1;
        instr_addr_o = branch_i ? addr_i : addr_q;
        addr_load    = branch_i;
        if (instr_gnt_i) begin
          state_d = instr_err_pmp_i ? WAIT_JUMP : WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (branch_i) begin
          instr_addr_o = addr_i;
        end
        if (instr_rvalid_i) begin
          // response arriving with a branch is already stale
          drop_o = branch_i;
          if (fetch_en && (room_i || branch_i)) begin
            issue = 1'b1;
          end else begin
            state_d   = IDLE;
            addr_load = branch_i;
            rewind    = branch_i;
          end
        end else if (branch_i) begin
          // remember the target, wait for the stale word
          state_d   = WAIT_ABORTED;
          addr_load = 1'b1;
        end
      end

      WAIT_ABORTED: begin
        instr_addr_o = branch_i ? addr_i : addr_q;
        addr_load    = branch_i;
        if (instr_rvalid_i) begin
          drop_o = 1'b1;
          if (fetch_en) begin
            issue = 1'b1;
          end else begin
            state_d   = IDLE;
            addr_load = 1'b1;
            rewind    = 1'b1;
          end
        end
      end

      WAIT_JUMP: begin
        // the faulting word itself never reaches the consumer
        drop_o = instr_rvalid_i;
        if (branch_i) begin
          instr_addr_o = addr_i;
          if (out_q && !instr_rvalid_i) begin
            state_d   = WAIT_ABORTED;
            addr_load = 1'b1;
          end else if (fetch_en) begin
            issue = 1'b1;
          end else begin
            state_d   = IDLE;
            addr_load = 1'b1;
            rewind    = 1'b1;
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // common request path for every state that may start a fetch
    if (issue) begin
      instr_req_o = 1'b1;
      addr_load   = 1'b1;
      if (!instr_gnt_i) begin
        state_d = WAIT_GNT;
      end else if (instr_err_pmp_i) begin
        state_d = WAIT_JUMP;
      end else begin
        state_d = WAIT_RVALID;
      end
    end

    // rewound target makes next_addr land exactly on it
    addr_d = rewind ? (instr_addr_o - WORD_BYTES) : instr_addr_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
      out_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      out_q   <= (instr_req_o & instr_gnt_i) | (out_q & ~instr_rvalid_i);
      if (addr_load) begin
        addr_q <= addr_d;
      end
    end
  end

endmodule

//--- hw/fetch_pkg.sv
// shared fetch types; 32-bit word addressed fetch only, no compressed instructions
package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic data types
  ////////////////////////////////////////////////////////////////////////////

  // byte address as seen by the instruction memory
  typedef logic [31:0] addr_t;

  // raw instruction word, no predecode bits
  typedef logic [31:0] instr_t;

  // sequential fetch step, one 32-bit word
  localparam addr_t WORD_BYTES = 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // fetch controller states
  ////////////////////////////////////////////////////////////////////////////

  // IDLE          nothing outstanding, may issue a request
  // WAIT_GNT      request driven, memory has not granted yet
  // WAIT_RVALID   request granted, waiting for its response
  // WAIT_ABORTED  response in flight is stale after a redirect
  // WAIT_JUMP     fetch fault seen, only a branch restarts fetching
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_JUMP
  } fetch_state_e;

  // three state bits leave room for three spare encodings
  // the controller sends any of them back to IDLE

endpackage
